// File: Bender.yml
package:
  name: riscvCore

export_include_dirs:
  - include

sources:
  - files:
      - verilog/riscvPkg.sv
      - verilog/wbBus.sv
      - verilog/fetchUnit.sv
      - verilog/coreControl.sv
      - verilog/regFile.sv
      - verilog/execUnit.sv
      - verilog/loadStoreUnit.sv
      - verilog/riscvCore.sv
  - target: simulation
    files:
      - sim/riscvCoreTb.sv

// File: include/riscvCore_cfg.svh
`ifndef RISCVCORE_CFG_SVH
`define RISCVCORE_CFG_SVH

// Byte address width of both buses
`define RV_ADDR_WIDTH 12

// First fetch address
`define RV_RESET_PC 0

`endif

// File: riscvCore.f
+incdir+include
verilog/riscvPkg.sv
verilog/wbBus.sv
verilog/fetchUnit.sv
verilog/coreControl.sv
verilog/regFile.sv
verilog/execUnit.sv
verilog/loadStoreUnit.sv
verilog/riscvCore.sv
sim/riscvCoreTb.sv

// File: sim/riscvCoreTb.sv
`default_nettype none

`include "riscvCore_cfg.svh"

module riscvCoreTb
	import riscvPkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	logic clk;
	logic arstN;
	tAddr iwbAdr;
	logic iwbCyc;
	logic iwbStb;
	tWord iwbDatR;
	logic iwbAck;
	tAddr dwbAdr;
	tWord dwbDatW;
	tWord dwbDatR;
	tSel dwbSel;
	logic dwbWe;
	logic dwbCyc;
	logic dwbStb;
	logic dwbAck;
	logic halt;
	tWord numInst;
	tWord outputPort;

	tWord iMem [1024];
	tWord dMem [1024];
	tWord expOut [$];
	tAddr expFetch [$];
	tAddr stAdr [$];
	tWord stDat [$];
	tSel stSel [$];
	tWord expCount;
	tWord lastCount;
	tAddr nextFetch; // Expected address of the next instruction fetch
	integer seed = 13654;
	int progWords;
	int cycles;
	int cycleLimit;
	int iWaits;
	int dWaits;
	logic running;
	logic iActive;
	logic dActive;
	tAddr iAdrHeld;
	tAddr dAdrHeld;
	tSel dSelHeld;
	logic dWeHeld;
	tWord dDatHeld;

	riscvCore riscvCore_i (
		.clk        (clk),
		.arstN      (arstN),
		.iwbAdr     (iwbAdr),
		.iwbCyc     (iwbCyc),
		.iwbStb     (iwbStb),
		.iwbDatR    (iwbDatR),
		.iwbAck     (iwbAck),
		.dwbAdr     (dwbAdr),
		.dwbDatW    (dwbDatW),
		.dwbDatR    (dwbDatR),
		.dwbSel     (dwbSel),
		.dwbWe      (dwbWe),
		.dwbCyc     (dwbCyc),
		.dwbStb     (dwbStb),
		.dwbAck     (dwbAck),
		.halt       (halt),
		.numInst    (numInst),
		.outputPort (outputPort)
	);

	always #50 clk = ~clk;

	task automatic stopWithFailure(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	task automatic compareWord(input string name, input tWord act, input tWord exp);
		if (act !== exp)
			stopWithFailure($sformatf("** Error at %0t ns: %s expected %h, got %h",
				$time, name, exp, act));
	endtask

	task automatic compareAddr(input string name, input tAddr act, input tAddr exp);
		if (act !== exp)
			stopWithFailure($sformatf("** Error at %0t ns: %s expected %h, got %h",
				$time, name, exp, act));
	endtask

	task automatic compareSel(input string name, input tSel act, input tSel exp);
		if (act !== exp)
			stopWithFailure($sformatf("** Error at %0t ns: %s expected %b, got %b",
				$time, name, exp, act));
	endtask

	task automatic compareFlag(input string name, input logic act, input logic exp);
		if (act !== exp)
			stopWithFailure($sformatf("** Error at %0t ns: %s expected %b, got %b",
				$time, name, exp, act));
	endtask

	function automatic tWord laneMask(input tSel sel);
		return {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
	endfunction

	task automatic loadTestData();
		int fd;
		int rc;
		string tag;
		string rest;
		tWord a;
		tWord w;
		tWord s;
		fd = $fopen("sim/riscvCore_testdata.txt", "r");
		if (fd == 0)
			stopWithFailure("Could not open the test data file");
		while ($fscanf(fd, "%s", tag) == 1) begin
			case (tag)
				"#": rc = $fgets(rest, fd);
				"I": begin
					rc = $fscanf(fd, "%h %h", a, w);
					iMem[a[11:2]] = w;
					progWords++;
				end
				"D": begin
					rc = $fscanf(fd, "%h %h", a, w);
					dMem[a[11:2]] = w;
				end
				"R": begin
					rc = $fscanf(fd, "%h %h", w, a);
					expOut.push_back(w);
					expFetch.push_back(tAddr'(a));
				end
				"S": begin
					rc = $fscanf(fd, "%h %h %h", a, w, s);
					stAdr.push_back(tAddr'(a));
					stDat.push_back(w);
					stSel.push_back(tSel'(s));
				end
				"N": rc = $fscanf(fd, "%h", expCount);
				default: stopWithFailure($sformatf("Unknown tag %s in the test data file", tag));
			endcase
		end
		$fclose(fd);
	endtask

	// Read-only instruction memory slave
	task serveFetch();
		if (!iwbCyc) begin
			if (iActive)
				stopWithFailure("iwbCyc dropped before the instruction bus ack");
			iwbAck = 1'b0;
		end else if (iwbAck) begin
			stopWithFailure("iwbCyc stayed high in the cycle after its ack");
		end else if (!iActive) begin
			if (halt)
				stopWithFailure("An instruction fetch started after the core halted");
			compareFlag("iwbStb", iwbStb, 1'b1);
			compareAddr("iwbAdr", iwbAdr, nextFetch);
			iActive = 1'b1;
			iAdrHeld = iwbAdr;
			iWaits = $random(seed) & 3;
		end else begin
			compareFlag("iwbStb", iwbStb, 1'b1);
			compareAddr("iwbAdr", iwbAdr, iAdrHeld); // Held through wait states
		end
		if (iActive) begin
			if (iWaits == 0) begin
				iwbAck = 1'b1;
				iwbDatR = iMem[iwbAdr[11:2]];
				iActive = 1'b0;
			end else begin
				iWaits--;
			end
		end
	endtask

	// Data memory slave with byte lanes
	task serveData();
		tWord mask;
		if (!dwbCyc) begin
			if (dActive)
				stopWithFailure("dwbCyc dropped before the data bus ack");
			dwbAck = 1'b0;
		end else if (dwbAck) begin
			stopWithFailure("dwbCyc stayed high in the cycle after its ack");
		end else if (!dActive) begin
			if (halt)
				stopWithFailure("A data bus cycle started after the core halted");
			compareFlag("dwbStb", dwbStb, 1'b1);
			if (dwbWe) begin
				if (stAdr.size() == 0)
					stopWithFailure("The core wrote more stores than the test data expects");
				compareAddr("dwbAdr", dwbAdr, stAdr.pop_front());
				compareSel("dwbSel", dwbSel, stSel.pop_front());
				compareWord("dwbDatW", dwbDatW & laneMask(dwbSel), stDat.pop_front());
			end
			dActive = 1'b1;
			dAdrHeld = dwbAdr;
			dSelHeld = dwbSel;
			dWeHeld = dwbWe;
			dDatHeld = dwbDatW;
			dWaits = $random(seed) & 3;
		end else begin
			compareFlag("dwbStb", dwbStb, 1'b1);
			compareAddr("dwbAdr", dwbAdr, dAdrHeld);
			compareSel("dwbSel", dwbSel, dSelHeld);
			compareFlag("dwbWe", dwbWe, dWeHeld);
			compareWord("dwbDatW", dwbDatW, dDatHeld);
		end
		if (dActive) begin
			if (dWaits == 0) begin
				mask = laneMask(dwbSel);
				if (dwbWe)
					dMem[dwbAdr[11:2]] = (dMem[dwbAdr[11:2]] & ~mask) | (dwbDatW & mask);
				else
					dwbDatR = dMem[dwbAdr[11:2]];
				dwbAck = 1'b1;
				dActive = 1'b0;
			end else begin
				dWaits--;
			end
		end
	endtask

	always @(negedge clk) begin
		if (running) begin
			if (numInst !== lastCount) begin // One retire per increment
				compareWord("numInst", numInst, lastCount + 32'd1);
				if (expOut.size() == 0)
					stopWithFailure("More instructions retired than the test data expects");
				compareWord("outputPort", outputPort, expOut.pop_front());
				nextFetch = expFetch.pop_front();
				lastCount = numInst;
			end
			serveFetch();
			serveData();
		end
	end

	initial begin
		clk = 1'b0;
		arstN = 1'b0;
		iwbDatR = '0;
		iwbAck = 1'b0;
		dwbDatR = '0;
		dwbAck = 1'b0;
		running = 1'b0;
		iActive = 1'b0;
		dActive = 1'b0;
		lastCount = '0;
		expCount = '0;
		nextFetch = tAddr'(`RV_RESET_PC);
		progWords = 0;
		cycles = 0;
		for (int i = 0; i < 1024; i++) begin
			iMem[i] = 32'h0000_0013 | (i << 20); // addi x0, x0, i
			dMem[i] = 32'hc0de_0000 | i;
		end
		loadTestData();
		cycleLimit = 20 * (progWords + 3);

		repeat (8) @(negedge clk);
		arstN = 1'b1;
		compareAddr("iwbAdr", iwbAdr, tAddr'(`RV_RESET_PC));
		compareFlag("iwbCyc", iwbCyc, 1'b0);
		compareFlag("iwbStb", iwbStb, 1'b0);
		compareFlag("dwbCyc", dwbCyc, 1'b0);
		compareFlag("dwbStb", dwbStb, 1'b0);
		compareFlag("dwbWe", dwbWe, 1'b0);
		compareFlag("halt", halt, 1'b0);
		compareWord("numInst", numInst, '0);
		compareWord("outputPort", outputPort, '0);
		running = 1'b1;

		while (!halt) begin
			@(negedge clk);
			cycles++;
			if (cycles > cycleLimit)
				stopWithFailure("Timeout: the core did not halt within the cycle limit");
		end
		repeat (5) begin
			@(negedge clk);
			compareFlag("iwbCyc", iwbCyc, 1'b0);
			compareFlag("dwbCyc", dwbCyc, 1'b0);
			compareFlag("halt", halt, 1'b1);
		end
		compareWord("numInst", numInst, expCount);
		if (expOut.size() != 0 || stAdr.size() != 0) begin
			stopWithFailure("The core halted before all expected results were seen");
		end else begin
			$display("Result: PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: sim/riscvCore_testdata.txt
# I byteAddr word | D byteAddr word | R outputPort nextFetchAddr | S byteAddr maskedData sel
# N finalRetireCount, all values in hex
I 000 123450b7
I 004 ffb00113
I 008 002081b3
I 00c 40208233
I 010 00001297
I 014 00112333
I 018 001133b3
I 01c 40115413
I 020 00730463
I 024 00731463
I 028 00100493
I 02c 0080056f
I 030 00200493
I 034 04000593
I 038 00858667
I 048 10102023
I 04c 102002a3
I 050 10401523
I 054 10002683
I 058 20000703
I 05c 20104783
I 060 20200803
I 064 20304883
I 068 20201903
I 06c 20005983
I 070 10500a03
I 074 00100073
D 200 8091a2f3
R 12345000 004
R fffffffb 008
R 12344ffb 00c
R 12345005 010
R 00001010 014
R 00000001 018
R 00000000 01c
R fffffffd 020
R 00000024 024
R 0000002c 02c
R 00000030 034
R 00000040 038
R 0000003c 048
R 12345000 04c
R fffffffb 050
R 12345005 054
R 12345000 058
R fffffff3 05c
R 000000a2 060
R ffffff91 064
R 00000080 068
R ffff8091 06c
R 0000a2f3 070
R fffffffb 074
S 100 12345000 f
S 104 0000fb00 2
S 108 50050000 c
N 18

// File: verilog/coreControl.sv
`default_nettype none

module coreControl
	import riscvPkg::*;
(
	input wire clk,
	input wire arstN,
	input wire tWord instr,
	input wire fetchDone,
	input wire memDone,
	input wire branchTaken,
	output tCtrl ctrl,
	output logic fetchReq,
	output logic memReq,
	output logic regWe,
	output logic pcLoad,
	output logic retire,
	output logic halt,
	output tWord numInst
);
	tState state;
	logic busWait; // Request issued, waiting for its done pulse
	logic isEbreak;

	function automatic tAluOp aluFromFunct(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000: return alt ? aluSub : aluAdd;
			3'b001: return aluSll;
			3'b010: return aluSlt;
			3'b011: return aluSltu;
			3'b100: return aluXor;
			3'b101: return alt ? aluSra : aluSrl;
			3'b110: return aluOr;
			default: return aluAnd;
		endcase
	endfunction

	assign isEbreak = (instr == 32'h0010_0073);

	always_comb begin
		ctrl = '0;
		ctrl.aluOp = aluAdd;
		ctrl.srcA = aSrcRs1;
		ctrl.srcB = bSrcImm;
		ctrl.immFmt = immI;
		ctrl.wbSrc = wbAlu;
		ctrl.funct3 = instr[14:12];
		case (instr[6:0])
			7'b0110111: begin // LUI
				ctrl.aluOp = aluPassB;
				ctrl.srcA = aSrcZero;
				ctrl.immFmt = immU;
				ctrl.regWrite = 1'b1;
			end
			7'b0010111: begin // AUIPC
				ctrl.srcA = aSrcPc;
				ctrl.immFmt = immU;
				ctrl.regWrite = 1'b1;
			end
			7'b1101111: begin // JAL
				ctrl.immFmt = immJ;
				ctrl.jump = 1'b1;
				ctrl.wbSrc = wbPc4;
				ctrl.regWrite = 1'b1;
			end
			7'b1100111: begin // JALR takes its target from the ALU
				ctrl.jump = 1'b1;
				ctrl.jalr = 1'b1;
				ctrl.wbSrc = wbPc4;
				ctrl.regWrite = 1'b1;
			end
			7'b1100011: begin
				ctrl.immFmt = immB;
				ctrl.srcB = bSrcRs2;
				ctrl.aluOp = aluSub;
				ctrl.branch = 1'b1;
			end
			7'b0000011: begin
				ctrl.load = 1'b1;
				ctrl.wbSrc = wbLoad;
				ctrl.regWrite = 1'b1;
			end
			7'b0100011: begin
				ctrl.immFmt = immS;
				ctrl.store = 1'b1;
			end
			7'b0010011: begin // Only SRAI uses the funct7 bit
				ctrl.aluOp = aluFromFunct(instr[14:12], instr[30] && instr[13:12] == 2'b01);
				ctrl.regWrite = 1'b1;
			end
			7'b0110011: begin
				ctrl.aluOp = aluFromFunct(instr[14:12], instr[30]);
				ctrl.srcB = bSrcRs2;
				ctrl.regWrite = 1'b1;
			end
			default: ; // Unsupported opcodes retire as no-ops
		endcase
	end

	assign fetchReq = (state == sFetch) && !busWait;
	assign memReq = (state == sMemory) && !busWait;
	assign retire = (state == sWriteback);
	assign pcLoad = retire; // Taken or not, pcNext already holds the target
	assign regWe = retire && ctrl.regWrite && (instr[11:7] != 5'd0);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= sFetch;
			busWait <= 1'b0;
			halt <= 1'b0;
			numInst <= '0;
		end else begin
			if (fetchReq || memReq)
				busWait <= 1'b1;
			else if (fetchDone || memDone)
				busWait <= 1'b0;
			if (retire)
				numInst <= numInst + 32'd1;
			case (state)
				sFetch: if (fetchDone) state <= sDecode;
				sDecode: begin
					if (isEbreak) begin
						state <= sHalt;
						halt <= 1'b1;
					end else begin
						state <= sExecute;
					end
				end
				sExecute: state <= (ctrl.load || ctrl.store) ? sMemory : sWriteback;
				sMemory: if (memDone) state <= sWriteback;
				sWriteback: state <= sFetch;
				default: state <= sHalt;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/execUnit.sv
`default_nettype none

module execUnit
	import riscvPkg::*;
(
	input wire clk,
	input wire arstN,
	input wire tCtrl ctrl,
	input wire tWord instr,
	input wire tAddr pc,
	input wire tWord rs1Data,
	input wire tWord rs2Data,
	input wire tWord loadData,
	input wire retire,
	output tWord aluOut,
	output tAddr pcNext,
	output tWord wbData,
	output logic branchTaken,
	output tWord outputPort
);
	tWord imm;
	tWord opA;
	tWord opB;
	tWord aluRes;
	tAddr pcPlus4;
	tAddr target;
	logic cond;

	always_comb begin
		case (ctrl.immFmt)
			immS: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			immB: imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
			immU: imm = {instr[31:12], 12'b0};
			immJ: imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
			default: imm = {{20{instr[31]}}, instr[31:20]};
		endcase
	end

	always_comb begin
		case (ctrl.srcA)
			aSrcPc: opA = tWord'(pc);
			aSrcZero: opA = '0;
			default: opA = rs1Data;
		endcase
		opB = (ctrl.srcB == bSrcRs2) ? rs2Data : imm;
	end

	always_comb begin
		case (ctrl.aluOp)
			aluSub: aluRes = opA - opB;
			aluSll: aluRes = opA << opB[4:0];
			aluSlt: aluRes = {31'b0, $signed(opA) < $signed(opB)};
			aluSltu: aluRes = {31'b0, opA < opB};
			aluXor: aluRes = opA ^ opB;
			aluSrl: aluRes = opA >> opB[4:0];
			aluSra: aluRes = $signed(opA) >>> opB[4:0];
			aluOr: aluRes = opA | opB;
			aluAnd: aluRes = opA & opB;
			aluPassB: aluRes = opB;
			default: aluRes = opA + opB;
		endcase
	end

	// Operands stay put until writeback, so the register holds the result from sExecute on
	always_ff @(posedge clk)
		aluOut <= aluRes;

	always_comb begin
		case (ctrl.funct3)
			3'b000: cond = (rs1Data == rs2Data);
			3'b001: cond = (rs1Data != rs2Data);
			3'b100: cond = $signed(rs1Data) < $signed(rs2Data);
			3'b101: cond = $signed(rs1Data) >= $signed(rs2Data);
			3'b110: cond = rs1Data < rs2Data;
			3'b111: cond = rs1Data >= rs2Data;
			default: cond = 1'b0;
		endcase
	end

	assign branchTaken = ctrl.branch && cond;
	assign pcPlus4 = pc + tAddr'(4);
	assign target = pc + tAddr'(imm);

	always_comb begin
		if (ctrl.jalr)
			pcNext = tAddr'(aluOut) & ~tAddr'(1);
		else if (branchTaken || ctrl.jump)
			pcNext = target;
		else
			pcNext = pcPlus4;
	end

	always_comb begin
		case (ctrl.wbSrc)
			wbLoad: wbData = loadData;
			wbPc4: wbData = tWord'(pcPlus4); // Link address
			default: wbData = aluOut;
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			outputPort <= '0;
		end else if (retire) begin
			if (ctrl.regWrite)
				outputPort <= wbData;
			else if (ctrl.store)
				outputPort <= rs2Data;
			else if (ctrl.branch)
				outputPort <= tWord'(pcNext);
		end
	end

endmodule

`default_nettype wire

// File: verilog/fetchUnit.sv
`default_nettype none

`include "riscvCore_cfg.svh"

module fetchUnit
	import riscvPkg::*;
(
	input wire clk,
	input wire arstN,
	input wire fetchReq,
	input wire pcLoad,
	input wire tAddr pcNext,
	output tAddr pc,
	output tWord instr,
	output logic fetchDone,
	wbBus.master iBus
);
	logic busy; // Read cycle open on the bus

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= tAddr'(`RV_RESET_PC);
			busy <= 1'b0;
			fetchDone <= 1'b0;
		end else begin
			fetchDone <= 1'b0;
			if (pcLoad)
				pc <= pcNext;
			if (fetchReq) begin
				busy <= 1'b1;
			end else if (busy && iBus.ack) begin
				busy <= 1'b0;
				fetchDone <= 1'b1;
			end
		end
	end

	// Instruction register
	always_ff @(posedge clk) begin
		if (busy && iBus.ack)
			instr <= iBus.datR;
	end

	assign iBus.adr = pc; // PC is only reloaded after the fetch completes
	assign iBus.cyc = busy;
	assign iBus.stb = busy;
	assign iBus.we = 1'b0;
	assign iBus.sel = '1;
	assign iBus.datW = '0;

endmodule

`default_nettype wire

// File: verilog/loadStoreUnit.sv
`default_nettype none

module loadStoreUnit
	import riscvPkg::*;
(
	input wire clk,
	input wire arstN,
	input wire memReq,
	input wire store,
	input wire [2:0] funct3,
	input wire tWord addr,
	input wire tWord storeData,
	output tWord loadData,
	output logic memDone,
	wbBus.master dBus
);
	logic busy;
	logic [1:0] byteOff;
	tSel storeSel;
	tWord laneWord;
	tWord loadExt;

	assign byteOff = addr[1:0];

	always_comb begin
		case (funct3[1:0])
			2'b00: storeSel = tSel'(4'b0001 << byteOff);
			2'b01: storeSel = byteOff[1] ? 4'b1100 : 4'b0011;
			default: storeSel = 4'b1111;
		endcase
	end

	always_comb begin
		laneWord = dBus.datR >> {byteOff, 3'b000}; // Addressed lane down to bit 0
		case (funct3)
			3'b000: loadExt = {{24{laneWord[7]}}, laneWord[7:0]};
			3'b001: loadExt = {{16{laneWord[15]}}, laneWord[15:0]};
			3'b100: loadExt = {24'b0, laneWord[7:0]};
			3'b101: loadExt = {16'b0, laneWord[15:0]};
			default: loadExt = laneWord;
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			busy <= 1'b0;
			memDone <= 1'b0;
		end else begin
			memDone <= 1'b0;
			if (memReq) begin
				busy <= 1'b1;
			end else if (busy && dBus.ack) begin
				busy <= 1'b0;
				memDone <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (busy && dBus.ack && !store)
			loadData <= loadExt;
	end

	assign dBus.adr = tAddr'(addr & ~tWord'(3));
	assign dBus.sel = store ? storeSel : 4'b1111; // Loads read the whole word
	assign dBus.we = busy && store;
	assign dBus.cyc = busy;
	assign dBus.stb = busy;

	always_comb begin
		case (funct3[1:0])
			2'b00: dBus.datW = {4{storeData[7:0]}};
			2'b01: dBus.datW = {2{storeData[15:0]}};
			default: dBus.datW = storeData;
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/regFile.sv
`default_nettype none

module regFile
	import riscvPkg::*;
(
	input wire clk,
	input wire arstN,
	input wire tRegIdx ra1,
	input wire tRegIdx ra2,
	input wire tRegIdx wa,
	input wire we,
	input wire tWord wd,
	output tWord rd1,
	output tWord rd2
);
	tWord regs [1:31];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (we && wa != 5'd0) begin
			regs[wa] <= wd;
		end
	end

	assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1]; // x0 is hardwired
	assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

endmodule

`default_nettype wire

// File: verilog/riscvCore.sv
`default_nettype none

module riscvCore
	import riscvPkg::*;
(
	input wire clk,
	input wire arstN,
	output tAddr iwbAdr,
	output logic iwbCyc,
	output logic iwbStb,
	input wire tWord iwbDatR,
	input wire iwbAck,
	output tAddr dwbAdr,
	output tWord dwbDatW,
	input wire tWord dwbDatR,
	output tSel dwbSel,
	output logic dwbWe,
	output logic dwbCyc,
	output logic dwbStb,
	input wire dwbAck,
	output logic halt,
	output tWord numInst,
	output tWord outputPort
);
	tCtrl ctrl;
	tWord instr;
	tAddr pc;
	tAddr pcNext;
	tWord rs1Data;
	tWord rs2Data;
	tWord aluOut;
	tWord wbData;
	tWord loadData;
	logic fetchReq;
	logic fetchDone;
	logic memReq;
	logic memDone;
	logic regWe;
	logic pcLoad;
	logic retire;
	logic branchTaken;

	wbBus iBus();
	wbBus dBus();

	// Instruction bus is read-only with full lanes, so only part of it leaves the core
	assign iwbAdr = iBus.adr;
	assign iwbCyc = iBus.cyc;
	assign iwbStb = iBus.stb;
	assign iBus.datR = iwbDatR;
	assign iBus.ack = iwbAck;

	assign dwbAdr = dBus.adr;
	assign dwbDatW = dBus.datW;
	assign dwbSel = dBus.sel;
	assign dwbWe = dBus.we;
	assign dwbCyc = dBus.cyc;
	assign dwbStb = dBus.stb;
	assign dBus.datR = dwbDatR;
	assign dBus.ack = dwbAck;

	fetchUnit fetchUnit_i (
		.clk       (clk),
		.arstN     (arstN),
		.fetchReq  (fetchReq),
		.pcLoad    (pcLoad),
		.pcNext    (pcNext),
		.pc        (pc),
		.instr     (instr),
		.fetchDone (fetchDone),
		.iBus      (iBus.master)
	);

	coreControl coreControl_i (
		.clk         (clk),
		.arstN       (arstN),
		.instr       (instr),
		.fetchDone   (fetchDone),
		.memDone     (memDone),
		.branchTaken (branchTaken),
		.ctrl        (ctrl),
		.fetchReq    (fetchReq),
		.memReq      (memReq),
		.regWe       (regWe),
		.pcLoad      (pcLoad),
		.retire      (retire),
		.halt        (halt),
		.numInst     (numInst)
	);

	regFile regFile_i (
		.clk   (clk),
		.arstN (arstN),
		.ra1   (instr[19:15]),
		.ra2   (instr[24:20]),
		.wa    (instr[11:7]),
		.we    (regWe),
		.wd    (wbData),
		.rd1   (rs1Data),
		.rd2   (rs2Data)
	);

	execUnit execUnit_i (
		.clk         (clk),
		.arstN       (arstN),
		.ctrl        (ctrl),
		.instr       (instr),
		.pc          (pc),
		.rs1Data     (rs1Data),
		.rs2Data     (rs2Data),
		.loadData    (loadData),
		.retire      (retire),
		.aluOut      (aluOut),
		.pcNext      (pcNext),
		.wbData      (wbData),
		.branchTaken (branchTaken),
		.outputPort  (outputPort)
	);

	loadStoreUnit loadStoreUnit_i (
		.clk       (clk),
		.arstN     (arstN),
		.memReq    (memReq),
		.store     (ctrl.store),
		.funct3    (ctrl.funct3),
		.addr      (aluOut),
		.storeData (rs2Data),
		.loadData  (loadData),
		.memDone   (memDone),
		.dBus      (dBus.master)
	);

endmodule

`default_nettype wire

// File: verilog/riscvPkg.sv
`default_nettype none

`include "riscvCore_cfg.svh"

package riscvPkg;

	typedef logic [31:0] tWord;
	typedef logic [`RV_ADDR_WIDTH-1:0] tAddr;
	typedef logic [4:0] tRegIdx;
	typedef logic [3:0] tSel;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluSll, aluSlt, aluSltu, aluXor,
		aluSrl, aluSra, aluOr, aluAnd, aluPassB
	} tAluOp;

	typedef enum logic [2:0] {
		sFetch, sDecode, sExecute, sMemory, sWriteback, sHalt
	} tState;

	typedef enum logic [1:0] {aSrcRs1, aSrcPc, aSrcZero} tSrcA;
	typedef enum logic {bSrcRs2, bSrcImm} tSrcB;
	typedef enum logic [2:0] {immI, immS, immB, immU, immJ} tImmFmt;
	typedef enum logic [1:0] {wbAlu, wbLoad, wbPc4} tWbSrc;

	// Per-instruction control held stable from decode to writeback
	typedef struct packed {
		tAluOp aluOp;
		tSrcA srcA;
		tSrcB srcB;
		tImmFmt immFmt;
		tWbSrc wbSrc;
		logic branch;
		logic jump; // JAL and JALR
		logic jalr;
		logic load;
		logic store;
		logic regWrite;
		logic [2:0] funct3;
	} tCtrl;

endpackage

`default_nettype wire

// File: verilog/wbBus.sv
`default_nettype none

// Wishbone classic link between one master and one slave
interface wbBus
	import riscvPkg::*;
();
	tAddr adr;
	tWord datW;
	tWord datR;
	tSel sel;
	logic we;
	logic cyc;
	logic stb;
	logic ack;

	modport master(output adr, datW, sel, we, cyc, stb, input datR, ack);
	modport slave(input adr, datW, sel, we, cyc, stb, output datR, ack);

endinterface

`default_nettype wire
